// File: Makefile
# Verilator lint, simulation and clean for the register file datapath

VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = datapathTb
RTL_TOP   = datapathTop
FILELIST  = filelist.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: alu.sv
// 8-bit combinational alu
// add, subtract, logic ops, pass, invert and shift left
// carry is carry out, borrow on subtract, or the bit shifted out
`timescale 1ns/1ps

module alu (
    input  regFilePkg::aluOp_t   op,
    input  regFilePkg::regData_t left,
    input  regFilePkg::regData_t right,
    output regFilePkg::regData_t result,
    output logic                 carry,
    output logic                 zero
);
    import regFilePkg::*;

    logic [dataWidth:0] wide;  // result with carry bit on top

    always_comb begin
        wide = '0;  // logic ops leave carry clear
        case (op)
            opAdd: begin
                wide = {1'b0, left} + {1'b0, right};
            end
            opSub: begin
                wide = {1'b0, left} - {1'b0, right};  // top bit is borrow
            end
            opAnd: begin
                wide = {1'b0, left & right};
            end
            opOr: begin
                wide = {1'b0, left | right};
            end
            opXor: begin
                wide = {1'b0, left ^ right};
            end
            opPassL: begin
                wide = {1'b0, left};
            end
            opNotL: begin
                wide = {1'b0, ~left};
            end
            opShl: begin
                wide = {left, 1'b0};  // old bit 7 lands in carry
            end
            default: begin
                wide = '0;
            end
        endcase
    end

    assign result = wide[dataWidth-1:0];
    assign carry  = wide[dataWidth];
    assign zero   = (result == '0);

endmodule

// File: datapathCtrl.sv
// wishbone classic slave and datapath sequencer
// addresses 0..3 load or read registers, address 4 runs an alu command
// writes go latch, write, ack; reads ack one edge after the request
// last alu result and flags are kept for status reads
`timescale 1ns/1ps

module datapathCtrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  regFilePkg::busAddr_t adr,
    input  regFilePkg::busData_t datIn,
    output regFilePkg::busData_t datOut,
    output logic                 ack,
    output regFilePkg::aluOp_t   aluOp,
    input  regFilePkg::regData_t aluResult,
    input  logic                 aluCarry,
    input  logic                 aluZero,
    regPortIf.ctrl               ports
);
    import regFilePkg::*;

    ctrlState_t state;
    logic       isReg;       // address hits a register
    logic       isCmd;       // command / status word
    regAddr_t   cmdDest;
    regAddr_t   cmdLeft;
    regAddr_t   cmdRight;
    regData_t   lastResult;  // for status reads
    logic       zeroFlag;
    logic       carryFlag;
    busData_t   status;

    // address decode, bus is held stable until ack
    assign isReg = (adr < busAddr_t'(regCount));
    assign isCmd = (adr == cmdAddr);

    // command fields
    assign aluOp    = aluOp_t'(datIn[cmdOpLsb +: 3]);
    assign cmdDest  = datIn[cmdDestLsb +: 2];
    assign cmdLeft  = datIn[cmdLeftLsb +: 2];
    assign cmdRight = datIn[cmdRightLsb +: 2];

    // sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= stIdle;
            lastResult <= '0;
            zeroFlag   <= 1'b0;
            carryFlag  <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (cyc && stb) begin
                        state <= we ? stLatch : stAck;  // reads skip the write path
                    end
                end
                stLatch: begin
                    state <= stWrite;
                    if (we && isCmd) begin  // flags taken with the result
                        lastResult <= aluResult;
                        zeroFlag   <= aluZero;
                        carryFlag  <= aluCarry;
                    end
                end
                stWrite: begin
                    state <= stAck;
                end
                default: begin
                    state <= stIdle;  // stAck, master drops stb next
                end
            endcase
        end
    end

    assign ack = (state == stAck);

    // write side: data steered every cycle, captured by the input register
    assign ports.wrData  = isCmd ? aluResult : datIn[dataWidth-1:0];
    assign ports.wrAddr  = isCmd ? cmdDest : adr[1:0];
    assign ports.wrEnN   = !(state == stWrite && (isReg || isCmd));  // unmapped writes ignored

    // read side: operands during latch, register readback during ack
    assign ports.rdLAddr = isCmd ? cmdLeft : adr[1:0];
    assign ports.rdRAddr = cmdRight;
    assign ports.rdLEnN  = !((state == stLatch && we && isCmd) ||
                             (state == stAck && !we && isReg));
    assign ports.rdREnN  = !(state == stLatch && we && isCmd);

    // status word
    always_comb begin
        status                  = '0;
        status[dataWidth-1:0]   = lastResult;
        status[statZeroBit]     = zeroFlag;
        status[statCarryBit]    = carryFlag;
    end

    // read data, valid while ack is high
    always_comb begin
        datOut = '0;
        if (state == stAck && !we) begin
            if (isReg) begin
                datOut = {{(busWidth-dataWidth){1'b0}}, ports.rdLData};
            end else if (isCmd) begin
                datOut = status;
            end
        end
    end

endmodule

// File: datapathTb.sv
// testbench for the register file datapath
// drives wishbone accesses, keeps a shadow of the four registers and the
// status word, and compares every read against it
`timescale 1ns/1ps

module datapathTb;
    import regFilePkg::*;

    localparam int ackLimit  = 20;   // edges before an access counts as hung
    localparam int streamLen = 200;  // random mixed accesses

    logic     clk = 1'b0;
    logic     rst;
    logic     cyc;
    logic     stb;
    logic     we;
    busAddr_t adr;
    busData_t datIn;
    busData_t datOut;
    logic     ack;

    regData_t    shadowRegs [regCount];  // expected register contents
    busData_t    shadowStatus;           // expected status word
    busData_t    gotQ [$];               // reads waiting for the checker
    busData_t    expQ [$];
    string       labelQ [$];
    event        readDone;
    busData_t    cmpGot;
    busData_t    cmpExp;
    string       cmpLabel;
    int          passCount;
    int          failCount;
    int          testFails;  // errors in the running test

    datapathTop dut_i (
        .clk    (clk),
        .rst    (rst),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datIn  (datIn),
        .datOut (datOut),
        .ack    (ack)
    );

    always #20 clk = ~clk;  // 40 ns period

    // expected status word with carry in bit 9 and zero in bit 8 over the result byte
    function automatic busData_t refAlu(aluOp_t op, regData_t l, regData_t r);
        regData_t res;
        logic     cy;
        int       sum;
        busData_t stat;
        res = '0;
        cy  = 1'b0;  // logic ops never carry
        case (op)
            opAdd: begin
                sum = int'(l) + int'(r);
                res = regData_t'(sum);
                cy  = (sum > 255);  // carry out of bit 7
            end
            opSub: begin
                res = l - r;
                cy  = (r > l);  // borrow
            end
            opAnd:   res = l & r;
            opOr:    res = l | r;
            opXor:   res = l ^ r;
            opPassL: res = l;
            opNotL:  res = ~l;
            opShl: begin
                res = {l[6:0], 1'b0};
                cy  = l[7];  // bit shifted out
            end
            default: res = '0;
        endcase
        stat       = '0;
        stat[7:0]  = res;
        stat[8]    = (res == 8'h00);
        stat[9]    = cy;
        return stat;
    endfunction

    function automatic regData_t randByte();
        return regData_t'($urandom());
    endfunction

    function automatic regAddr_t randAddr();
        return regAddr_t'($urandom());
    endfunction

    task automatic stopOnHang(input string what);
        $display("bus access hung: %s got no ack within %0d cycles", what, ackLimit);
        $display("Done: errors found");
        $finish;
    endtask

    // classic write with ack expected on the third edge
    task automatic busWrite(input busAddr_t a, input busData_t d);
        int edges;
        edges = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        datIn = d;
        while (!ack && edges < ackLimit) begin
            @(negedge clk);
            edges++;
        end
        if (!ack) begin
            stopOnHang($sformatf("write to address %0d", a));
        end else begin
            cyc = 1'b0;  // drop strobe right after ack
            stb = 1'b0;
            we  = 1'b0;
            if (edges != 3) begin
                $display("CHECK FAILED at time %0t: write to %0d acked after %0d edges, expected 3",
                         $time, a, edges);
                failCount++;
                testFails++;
            end else begin
                passCount++;
            end
        end
    endtask

    // classic read with ack expected on the first edge
    task automatic busRead(input busAddr_t a, output busData_t got);
        int edges;
        edges = 0;
        got   = '0;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        while (!ack && edges < ackLimit) begin
            @(negedge clk);
            edges++;
        end
        if (!ack) begin
            stopOnHang($sformatf("read of address %0d", a));
        end else begin
            got = datOut;  // stable mid cycle
            cyc = 1'b0;
            stb = 1'b0;
            if (edges != 1) begin
                $display("CHECK FAILED at time %0t: read of %0d acked after %0d edges, expected 1",
                         $time, a, edges);
                failCount++;
                testFails++;
            end else begin
                passCount++;
            end
        end
    endtask

    task automatic writeReg(input regAddr_t idx, input regData_t val);
        shadowRegs[idx] = val;
        busWrite({1'b0, idx}, {8'h00, val});
    endtask

    // operands taken from the shadow before the destination update
    task automatic runCmd(input aluOp_t op, input regAddr_t d, input regAddr_t l,
                          input regAddr_t r);
        busData_t word;
        busData_t exp;
        word       = '0;
        word[10:8] = op;
        word[5:4]  = d;
        word[3:2]  = l;
        word[1:0]  = r;
        exp           = refAlu(op, shadowRegs[l], shadowRegs[r]);
        shadowStatus  = exp;
        shadowRegs[d] = exp[7:0];
        busWrite(cmdAddr, word);
    endtask

    // read one word and hand it to the checker
    task automatic checkRead(input busAddr_t a, input string label);
        busData_t got;
        busData_t exp;
        if (a == cmdAddr) begin
            exp = shadowStatus;
        end else begin
            exp = {8'h00, shadowRegs[a[1:0]]};
        end
        busRead(a, got);
        gotQ.push_back(got);
        expQ.push_back(exp);
        labelQ.push_back(label);
        ->readDone;
    endtask

    task automatic finishTest(input string name);
        #1;  // let the checker drain
        if (testFails == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, testFails);
        end
        testFails = 0;
    endtask

    // compares every read against the shadow
    always begin
        @(readDone);
        while (gotQ.size() > 0) begin
            cmpGot   = gotQ.pop_front();
            cmpExp   = expQ.pop_front();
            cmpLabel = labelQ.pop_front();
            if (cmpGot !== cmpExp) begin
                $display("CHECK FAILED at time %0t: %s read %h, expected %h",
                         $time, cmpLabel, cmpGot, cmpExp);
                failCount++;
                testFails++;
            end else begin
                passCount++;
            end
        end
    end

    initial begin
        regAddr_t victim;
        regAddr_t d;
        regAddr_t l;
        regAddr_t r;
        aluOp_t   op;
        busAddr_t a;
        void'($urandom(32'hd91a_593c));  // one seed for the run
        rst          = 1'b1;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        datIn        = '0;
        passCount    = 0;
        failCount    = 0;
        testFails    = 0;
        shadowStatus = '0;  // flags clear out of reset
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // reset state and access latency
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("CHECK FAILED at time %0t: ack high after reset", $time);
            failCount++;
            testFails++;
        end else begin
            passCount++;
        end
        checkRead(cmdAddr, "status after reset");
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("CHECK FAILED at time %0t: ack held longer than one cycle", $time);
            failCount++;
            testFails++;
        end else begin
            passCount++;
        end
        writeReg(2'd0, randByte());
        checkRead(3'd0, "r0 first load");
        finishTest("reset and latency");

        // load, read back, overwrite one
        for (int i = 0; i < regCount; i++) begin
            writeReg(regAddr_t'(i), randByte());
        end
        for (int i = 0; i < regCount; i++) begin
            checkRead(busAddr_t'(i), $sformatf("r%0d load", i));
        end
        victim = randAddr();
        writeReg(victim, randByte());
        for (int i = 0; i < regCount; i++) begin
            checkRead(busAddr_t'(i), $sformatf("r%0d after overwrite of r%0d", i, victim));
        end
        finishTest("register loads");

        // every opcode on fresh random operands
        for (int rep = 0; rep < 2; rep++) begin
            for (int k = 0; k < 8; k++) begin
                op = aluOp_t'(3'(k));
                d  = randAddr();
                l  = randAddr();
                r  = randAddr();
                writeReg(l, randByte());
                writeReg(r, randByte());
                runCmd(op, d, l, r);
                checkRead({1'b0, d}, $sformatf("%s dest r%0d", op.name(), d));
                checkRead(cmdAddr, $sformatf("%s status", op.name()));
            end
        end
        finishTest("every opcode");

        // source and destination the same register
        writeReg(2'd1, randByte());
        runCmd(opAdd, 2'd1, 2'd1, 2'd1);  // r1 + r1 into r1
        checkRead(3'd1, "add r1 r1 into r1");
        checkRead(cmdAddr, "add r1 r1 status");
        for (int k = 0; k < 8; k++) begin
            op = aluOp_t'(3'(k));
            d  = randAddr();
            writeReg(d, randByte());
            runCmd(op, d, d, d);
            checkRead({1'b0, d}, $sformatf("aliased %s r%0d", op.name(), d));
            checkRead(cmdAddr, $sformatf("aliased %s status", op.name()));
        end
        finishTest("aliased registers");

        // mixed random stream
        for (int n = 0; n < streamLen; n++) begin
            case ($urandom() % 3)
                0: writeReg(randAddr(), randByte());
                1: runCmd(aluOp_t'(3'($urandom())), randAddr(), randAddr(), randAddr());
                default: begin
                    a = busAddr_t'($urandom() % 5);  // registers or status
                    checkRead(a, $sformatf("stream step %0d address %0d", n, a));
                end
            endcase
        end
        finishTest("random stream");

        @(negedge clk);
        $display("checks passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: datapathTop.sv
// register file datapath top level
// wishbone slave controller, synchronous register file and alu
// joined through one port bundle
`timescale 1ns/1ps

module datapathTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  regFilePkg::busAddr_t adr,
    input  regFilePkg::busData_t datIn,
    output regFilePkg::busData_t datOut,
    output logic                 ack
);
    import regFilePkg::*;

    aluOp_t   aluOp;      // opcode from the command word
    regData_t aluResult;
    logic     aluCarry;
    logic     aluZero;

    regPortIf regPorts ();

    datapathCtrl ctrl (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .datIn     (datIn),
        .datOut    (datOut),
        .ack       (ack),
        .aluOp     (aluOp),
        .aluResult (aluResult),
        .aluCarry  (aluCarry),
        .aluZero   (aluZero),
        .ports     (regPorts.ctrl)
    );

    syncRegisterFile regs (
        .clk   (clk),
        .ports (regPorts.regs)
    );

    // operands straight off the two read ports
    alu aluUnit (
        .op     (aluOp),
        .left   (regPorts.rdLData),
        .right  (regPorts.rdRData),
        .result (aluResult),
        .carry  (aluCarry),
        .zero   (aluZero)
    );

endmodule

// File: filelist.f
regFilePkg.sv
regPortIf.sv
registerBank.sv
registerFile.sv
syncRegisterFile.sv
alu.sv
datapathCtrl.sv
datapathTop.sv
datapathTb.sv

// File: regFilePkg.sv
// register file datapath package
// widths, shared types, opcode and state encodings, bus address map
package regFilePkg;

    localparam int dataWidth   = 8;   // register and alu word
    localparam int nibbleWidth = 4;   // one bank word
    localparam int regCount    = 4;   // registers in the file
    localparam int busWidth    = 16;  // wishbone data width

    typedef logic [dataWidth-1:0]   regData_t;
    typedef logic [nibbleWidth-1:0] nibble_t;
    typedef logic [1:0]             regAddr_t;  // register index
    typedef logic [busWidth-1:0]    busData_t;
    typedef logic [2:0]             busAddr_t;  // wishbone word address

    typedef enum logic [2:0] {
        opAdd, opSub, opAnd, opOr, opXor, opPassL, opNotL, opShl
    } aluOp_t;

    typedef enum logic [1:0] {
        stIdle, stLatch, stWrite, stAck
    } ctrlState_t;

    // bus map: 0..3 registers, 4 command / status
    localparam busAddr_t cmdAddr = 3'd4;

    // command word fields
    localparam int cmdOpLsb    = 8;  // opcode 10:8
    localparam int cmdDestLsb  = 4;  // destination 5:4
    localparam int cmdLeftLsb  = 2;  // left source 3:2
    localparam int cmdRightLsb = 0;  // right source 1:0

    // status word fields, result in low byte
    localparam int statZeroBit  = 8;
    localparam int statCarryBit = 9;

endpackage

// File: regPortIf.sv
// register file port bundle
// one write port and two read ports, controller side and array side
`timescale 1ns/1ps

interface regPortIf;
    import regFilePkg::*;

    logic      wrEnN;    // active low write strobe
    regAddr_t  wrAddr;
    regData_t  wrData;
    logic      rdLEnN;   // left read enable, active low
    regAddr_t  rdLAddr;
    logic      rdREnN;   // right read enable, active low
    regAddr_t  rdRAddr;
    regData_t  rdLData;  // zero when disabled
    regData_t  rdRData;

    modport ctrl (
        output wrEnN, wrAddr, wrData,
        output rdLEnN, rdLAddr,
        output rdREnN, rdRAddr,
        input  rdLData, rdRData
    );

    modport regs (
        input  wrEnN, wrAddr, wrData,
        input  rdLEnN, rdLAddr,
        input  rdREnN, rdRAddr,
        output rdLData, rdRData
    );

endinterface

// File: registerBank.sv
// 4x4 register bank
// one write port, two independent read ports, all enables active low
// disabled read port returns zero instead of floating
`timescale 1ns/1ps

module registerBank (
    input  logic                clk,
    input  logic                wrEnN,
    input  regFilePkg::regAddr_t wrAddr,
    input  regFilePkg::nibble_t  wrData,
    input  logic                rdLEnN,
    input  regFilePkg::regAddr_t rdLAddr,
    input  logic                rdREnN,
    input  regFilePkg::regAddr_t rdRAddr,
    output regFilePkg::nibble_t  rdLData,
    output regFilePkg::nibble_t  rdRData
);
    import regFilePkg::*;

    nibble_t words [regCount];  // storage, no reset like the real part

    // write on the edge while strobe is low
    always_ff @(posedge clk) begin
        if (!wrEnN) begin
            words[wrAddr] <= wrData;
        end
    end

    // read ports are flow-through
    always_comb begin
        rdLData = '0;  // disabled port reads zero
        if (!rdLEnN) begin
            rdLData = words[rdLAddr];
        end
    end

    always_comb begin
        rdRData = '0;
        if (!rdREnN) begin
            rdRData = words[rdRAddr];
        end
    end

endmodule

// File: registerFile.sv
// 4x8 dual port register array
// low and high nibble banks share addresses and enables,
// the byte is split on write and joined again on both reads
`timescale 1ns/1ps

module registerFile (
    input logic clk,
    regPortIf.regs ports
);
    import regFilePkg::*;

    nibble_t wrLo, wrHi;
    nibble_t rdLLo, rdLHi;
    nibble_t rdRLo, rdRHi;

    assign wrLo = ports.wrData[nibbleWidth-1:0];
    assign wrHi = ports.wrData[dataWidth-1 -: nibbleWidth];

    registerBank bankLo (
        .clk     (clk),
        .wrEnN   (ports.wrEnN),
        .wrAddr  (ports.wrAddr),
        .wrData  (wrLo),
        .rdLEnN  (ports.rdLEnN),
        .rdLAddr (ports.rdLAddr),
        .rdREnN  (ports.rdREnN),
        .rdRAddr (ports.rdRAddr),
        .rdLData (rdLLo),
        .rdRData (rdRLo)
    );

    registerBank bankHi (
        .clk     (clk),
        .wrEnN   (ports.wrEnN),
        .wrAddr  (ports.wrAddr),
        .wrData  (wrHi),
        .rdLEnN  (ports.rdLEnN),
        .rdLAddr (ports.rdLAddr),
        .rdREnN  (ports.rdREnN),
        .rdRAddr (ports.rdRAddr),
        .rdLData (rdLHi),
        .rdRData (rdRHi)
    );

    // rejoin nibbles into bytes
    assign ports.rdLData = {rdLHi, rdLLo};
    assign ports.rdRData = {rdRHi, rdRLo};

endmodule

// File: syncRegisterFile.sv
// synchronous front end for the 4x8 register file
// write data goes through an input register clocked every edge,
// so the array sees a settled byte before the write strobe drops
// addresses, enables and read data pass straight through
`timescale 1ns/1ps

module syncRegisterFile (
    input logic clk,
    regPortIf.regs ports
);
    import regFilePkg::*;

    regData_t wrDataQ;  // input register output
    regPortIf arrayPorts ();  // array side bundle

    // input register, loads on every rising edge
    always_ff @(posedge clk) begin
        wrDataQ <= ports.wrData;
    end

    // array gets the captured byte, not the live bus
    assign arrayPorts.wrData  = wrDataQ;
    assign arrayPorts.wrEnN   = ports.wrEnN;
    assign arrayPorts.wrAddr  = ports.wrAddr;
    assign arrayPorts.rdLEnN  = ports.rdLEnN;
    assign arrayPorts.rdLAddr = ports.rdLAddr;
    assign arrayPorts.rdREnN  = ports.rdREnN;
    assign arrayPorts.rdRAddr = ports.rdRAddr;

    registerFile regFile (
        .clk   (clk),
        .ports (arrayPorts.regs)
    );

    // read data back out unchanged
    assign ports.rdLData = arrayPorts.rdLData;
    assign ports.rdRData = arrayPorts.rdRData;

endmodule
